//--- tb.f
common/fetch_pkg.sv
common/icache_if.sv
icache/icache_word.sv
icache/icache_compressed.sv
rtl/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fetch_tb -f tb.f -o fetch_sim

sim_out=$(./obj_dir/fetch_sim 2>&1 || true)
echo "$sim_out"
if echo "$sim_out" | grep -q "TEST OK"; then
    exit 0
fi
exit 1

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the fetch path
// Every response is compared with a halfword model of the store contents
module fetch_tb;

    logic                                clk;
    logic                                rstn;
    logic                                req_valid;
    logic [fetch_pkg::xlen-1:0]          req_pc;
    fetch_pkg::if_reason_t               req_reason;
    logic                                resp_valid;
    logic [fetch_pkg::xlen-1:0]          resp_pc;
    logic [31:0]                         resp_instr;
    logic                                resp_exception;
    logic                                fill_valid;
    logic [fetch_pkg::mem_addr_bits-1:0] fill_addr;
    logic [31:0]                         fill_data;

    // Same contents as the store, one entry per halfword
    logic [15:0] model_half [fetch_pkg::mem_words * 2];

    integer seed;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    fetch_top u_dut (.*);

    always #5 clk = ~clk;

    task automatic check_instr(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: resp_instr expected %h got %h", $time, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pc(input logic [fetch_pkg::xlen-1:0] exp,
                            input logic [fetch_pkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: resp_pc expected %h got %h", $time, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_exc(input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: resp_exception expected %b got %b", $time, exp, act);
            test_errors++;
        end
    endtask

    // Half the halfwords get 11 in the low bits so 32-bit and compressed code mix
    task automatic random_half(output logic [15:0] h);
        logic [31:0] r;
        r = $random(seed);
        h = r[15:0];
        if (r[20]) begin
            h[1:0] = 2'b11;
        end
    endtask

    // Caller drops fill_valid once the last word is out
    task automatic fill_word(input int w, input logic [31:0] data);
        model_half[2*w]   = data[15:0];
        model_half[2*w+1] = data[31:16];
        @(posedge clk);
        fill_valid <= 1'b1;
        fill_addr  <= w[fetch_pkg::mem_addr_bits-1:0];
        fill_data  <= data;
    endtask

    // Expected answer for a fetch at pc, following the RISC-V length rule on the low bits
    task automatic expect_fetch(input logic [fetch_pkg::xlen-1:0] pc, output logic exc,
                                output logic [fetch_pkg::xlen-1:0] epc,
                                output logic [31:0] instr,
                                output logic [fetch_pkg::xlen-1:0] len);
        logic [fetch_pkg::mem_addr_bits:0]  idx;
        logic [fetch_pkg::xlen-1:0]         next_word;
        logic [15:0]                        low;
        next_word = {pc[fetch_pkg::xlen-1:2], 2'b00} + 64'd4;
        idx       = pc[fetch_pkg::mem_addr_bits+1:1];
        exc       = 1'b0;
        epc       = pc;
        instr     = '0;
        len       = 2;
        if (pc >= fetch_pkg::mem_limit) begin
            exc = 1'b1;
        end else begin
            low = model_half[idx];
            if (low[1:0] != 2'b11) begin
                instr = {16'b0, low};
            end else if (pc[1] && next_word >= fetch_pkg::mem_limit) begin
                // The upper half would come from the word past the end
                exc = 1'b1;
                epc = next_word;
                len = 4;
            end else begin
                instr = {model_half[idx + 1'b1], low};
                len   = 4;
            end
        end
    endtask

    task automatic fetch_check(input logic [fetch_pkg::xlen-1:0] pc,
                               input fetch_pkg::if_reason_t reason,
                               output logic [fetch_pkg::xlen-1:0] len, output logic exc);
        logic [fetch_pkg::xlen-1:0] exp_pc;
        logic [31:0]                exp_instr;
        int                         waited;
        expect_fetch(pc, exc, exp_pc, exp_instr, len);
        @(posedge clk);
        req_valid  <= 1'b1;
        req_pc     <= pc;
        req_reason <= reason;
        @(posedge clk);
        req_valid <= 1'b0;
        // Outputs are looked at on the falling edge, away from the clocked updates
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!resp_valid && waited < 10);
        if (!resp_valid) begin
            $display("no response arrived within 10 cycles for pc %h", pc);
            test_errors++;
        end else begin
            check_exc(exc, resp_exception);
            check_pc(exp_pc, resp_pc);
            if (!exc) begin
                check_instr(exp_instr, resp_instr);
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors, %s", name, test_errors, test_errors == 0 ? "pass" : "fail");
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        logic [31:0]                r;
        logic [15:0]                lo;
        logic [15:0]                hi;
        logic [fetch_pkg::xlen-1:0] pc;
        logic [fetch_pkg::xlen-1:0] len;
        logic                       exc;
        logic                       redirect;
        fetch_pkg::if_reason_t      reason;
        seed         = 32'h35fb;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        clk          = 1'b0;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_pc       = '0;
        req_reason   = fetch_pkg::if_prefetch;
        fill_valid   = 1'b0;
        fill_addr    = '0;
        fill_data    = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (int w = 0; w < fetch_pkg::mem_words; w++) begin
            random_half(lo);
            random_half(hi);
            fill_word(w, {hi, lo});
        end
        @(posedge clk);
        fill_valid <= 1'b0;

        repeat (40) begin
            r  = $random(seed);
            pc = '0;
            pc[fetch_pkg::mem_addr_bits+1:2] = r[fetch_pkg::mem_addr_bits-1:0];
            fetch_check(pc, fetch_pkg::if_predict, len, exc);
        end
        finish_test("aligned_streams");

        // Odd halfwords only, so every 32-bit hit straddles two words
        repeat (40) begin
            r  = $random(seed);
            pc = '0;
            pc[fetch_pkg::mem_addr_bits+1:2] = r[fetch_pkg::mem_addr_bits-1:0];
            pc[1] = 1'b1;
            fetch_check(pc, fetch_pkg::if_mispredict, len, exc);
        end
        finish_test("halfword_redirects");

        // A redirect first, so the buffer left over from earlier tests is not trusted
        pc = '0;
        fetch_check(pc, fetch_pkg::if_mispredict, len, exc);
        repeat (200) begin
            pc = pc + len;
            fetch_check(pc, fetch_pkg::if_prefetch, len, exc);
        end
        finish_test("sequential_prefetch");

        // Runs of prefetches broken by redirects to any halfword
        // A fault or the end of the store forces the next request to be a redirect
        redirect = 1'b1;
        repeat (150) begin
            r = $random(seed);
            if (redirect || r[3:0] < 4'd4) begin
                pc = '0;
                pc[fetch_pkg::mem_addr_bits+1:1] = r[fetch_pkg::mem_addr_bits+16:16];
                reason = r[8] ? fetch_pkg::if_predict : fetch_pkg::if_mispredict;
            end else begin
                pc     = pc + len;
                reason = fetch_pkg::if_prefetch;
            end
            fetch_check(pc, reason, len, exc);
            redirect = exc || (pc + len >= fetch_pkg::mem_limit);
        end
        finish_test("mixed_reasons");

        repeat (10) begin
            r  = $random(seed);
            pc = fetch_pkg::mem_limit;
            pc[fetch_pkg::mem_addr_bits+1:1] = r[fetch_pkg::mem_addr_bits:0];
            fetch_check(pc, fetch_pkg::if_predict, len, exc);
        end
        // Put a 32-bit instruction in the last halfword, its upper half lies past the end
        r = $random(seed);
        fill_word(fetch_pkg::mem_words - 1, {r[31:18], 2'b11, r[15:0]});
        @(posedge clk);
        fill_valid <= 1'b0;
        fetch_check(fetch_pkg::mem_limit - 64'd2, fetch_pkg::if_mispredict, len, exc);
        finish_test("range_exception");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/fetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the plain fetch ports of the top level
module fetch_chk (
    input logic clk,
    input logic rstn,
    input logic req_valid,
    input logic resp_valid,
    input logic resp_exception
);

    // Nothing may come back while reset is held
    resp_in_reset: assert property (@(posedge clk) !rstn |-> !resp_valid)
        else $error("resp_valid high while rstn is low");

    // A request seen two edges back with no answer on the last edge must be answered now
    resp_latency: assert property (@(posedge clk) disable iff (!rstn)
        ($past(req_valid, 2) && !$past(resp_valid)) |-> resp_valid)
        else $error("request not answered within two cycles");

    // Back-to-back responses need a fresh request in between
    resp_single: assert property (@(posedge clk) disable iff (!rstn)
        (resp_valid && $past(resp_valid)) |-> $past(req_valid))
        else $error("resp_valid held for two cycles without a request");

    resp_exc_known: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> !$isunknown(resp_exception))
        else $error("resp_exception unknown on a valid response");

endmodule

bind fetch_top fetch_chk u_chk (
    .clk            (clk),
    .rstn           (rstn),
    .req_valid      (req_valid),
    .resp_valid     (resp_valid),
    .resp_exception (resp_exception)
);

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction-fetch path
// The compressed adapter sits in front of the word store
module fetch_top (
    input  logic                                clk,
    input  logic                                rstn,

    // Fetch requests from the pipeline
    input  logic                                req_valid,
    input  logic [fetch_pkg::xlen-1:0]          req_pc,
    input  fetch_pkg::if_reason_t               req_reason,

    // Instructions going back to the pipeline
    output logic                                resp_valid,
    output logic [fetch_pkg::xlen-1:0]          resp_pc,
    output logic [31:0]                         resp_instr,
    output logic                                resp_exception,

    // Loader port, writes one word per cycle
    input  logic                                fill_valid,
    input  logic [fetch_pkg::mem_addr_bits-1:0] fill_addr,
    input  logic [31:0]                         fill_data
);

    // Pipeline to adapter
    icache_if fetch_bus (
        .clk  (clk),
        .rstn (rstn)
    );

    // Adapter to word store
    icache_if mem_bus (
        .clk  (clk),
        .rstn (rstn)
    );

    // The top's own ports play the user side of the fetch bus
    assign fetch_bus.req_valid  = req_valid;
    assign fetch_bus.req_pc     = req_pc;
    assign fetch_bus.req_reason = req_reason;

    assign resp_valid     = fetch_bus.resp_valid;
    assign resp_pc        = fetch_bus.resp_pc;
    assign resp_instr     = fetch_bus.resp_instr;
    assign resp_exception = fetch_bus.resp_exception;

    icache_compressed u_adapter (
        .cache (fetch_bus.provider),
        .mem   (mem_bus.user)
    );

    icache_word u_mem (
        .cache      (mem_bus.provider),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data)
    );

endmodule

`default_nettype wire

//--- icache/icache_compressed.sv
`timescale 1ns/1ps
`default_nettype none

// Lets the fetch stage ask for any halfword-aligned pc on top of a store that only
// returns whole aligned words
// A 32-bit instruction that straddles two words is put back together here
module icache_compressed (
    icache_if.provider cache,
    icache_if.user     mem
);

    // Plain local names for the bus signals
    logic                       clk;
    logic                       rstn;
    logic                       req_valid;
    logic [fetch_pkg::xlen-1:0] req_pc;
    fetch_pkg::if_reason_t      req_reason;
    logic                       mem_resp_valid;
    logic [fetch_pkg::xlen-1:0] mem_resp_pc;
    logic [31:0]                mem_resp_instr;
    logic                       mem_resp_exception;

    assign clk                = cache.clk;
    assign rstn               = cache.rstn;
    assign req_valid          = cache.req_valid;
    assign req_pc             = cache.req_pc;
    assign req_reason         = cache.req_reason;
    assign mem_resp_valid     = mem.resp_valid;
    assign mem_resp_pc        = mem.resp_pc;
    assign mem_resp_instr     = mem.resp_instr;
    assign mem_resp_exception = mem.resp_exception;

    // Values that the combinational block computes for both buses
    logic                       mem_req_valid;
    logic [fetch_pkg::xlen-1:0] mem_req_pc;
    fetch_pkg::if_reason_t      mem_req_reason;
    logic                       resp_valid;
    logic [fetch_pkg::xlen-1:0] resp_pc;
    logic [31:0]                resp_instr;
    logic                       resp_exception;

    // The pc of the request now in flight, returned as resp_pc
    logic [fetch_pkg::xlen-1:0] latched_pc, latched_pc_d;

    // One word past the last word sent to the store
    // Keeping it ready means no adder sits between a request and the store's pc
    logic [fetch_pkg::xlen-1:0] next_pc, next_pc_d;

    // High while the first word of a halfword-offset fetch is outstanding
    logic first_half, first_half_d;

    // Upper halfword of the last word that the response did not consume
    // The next sequential fetch starts with it
    logic [15:0] buf_half, buf_half_d;
    logic        buf_valid, buf_valid_d;

    always_comb begin
        // Nothing goes out unless a branch below decides so
        mem_req_valid  = 1'b0;
        mem_req_pc     = req_pc;
        mem_req_reason = req_reason;
        resp_valid     = 1'b0;
        resp_pc        = latched_pc;
        resp_instr     = '0;
        resp_exception = 1'b0;

        latched_pc_d = latched_pc;
        next_pc_d    = next_pc;
        first_half_d = first_half;
        buf_half_d   = buf_half;
        buf_valid_d  = buf_valid;

        if (mem_resp_valid) begin
            // Every returned word replaces whatever was buffered before
            buf_valid_d = 1'b0;

            if (mem_resp_exception) begin
                // The store's echoed pc tells which of the two words faulted
                resp_valid     = 1'b1;
                resp_pc        = mem_resp_pc;
                resp_exception = 1'b1;
                first_half_d   = 1'b0;
            end else if (first_half && mem_resp_instr[17:16] == 2'b11) begin
                // A 32-bit instruction starts in the upper half, so park that half
                // and ask for the following word right away
                buf_half_d     = mem_resp_instr[31:16];
                buf_valid_d    = 1'b1;
                mem_req_valid  = 1'b1;
                mem_req_pc     = next_pc;
                mem_req_reason = fetch_pkg::if_prefetch;
                next_pc_d      = next_pc + fetch_pkg::word_step;
                first_half_d   = 1'b0;
            end else begin
                resp_valid = 1'b1;
                if (!latched_pc[1]) begin
                    if (mem_resp_instr[1:0] == 2'b11) begin
                        // Aligned full-width instruction
                        resp_instr = mem_resp_instr;
                    end else begin
                        // Aligned compressed instruction
                        // Its upper neighbour is kept for the next prefetch
                        resp_instr  = {16'b0, mem_resp_instr[15:0]};
                        buf_half_d  = mem_resp_instr[31:16];
                        buf_valid_d = 1'b1;
                    end
                end else if (first_half) begin
                    // Offset fetch that found a compressed instruction in the upper half
                    resp_instr = {16'b0, mem_resp_instr[31:16]};
                end else begin
                    // Second word of a straddling instruction joins the buffered half
                    resp_instr  = {mem_resp_instr[15:0], buf_half};
                    buf_half_d  = mem_resp_instr[31:16];
                    buf_valid_d = 1'b1;
                end
            end
        end

        // A new request may land in the same cycle as a response, so it sees
        // the buffer as that response leaves it
        if (req_valid) begin
            mem_req_valid  = 1'b1;
            mem_req_pc     = req_pc;
            mem_req_reason = req_reason;
            latched_pc_d   = req_pc;
            next_pc_d      = {req_pc[fetch_pkg::xlen-1:2], 2'b00} + fetch_pkg::word_step;
            first_half_d   = req_pc[1];

            if (buf_valid_d && req_reason == fetch_pkg::if_prefetch &&
                buf_half_d[1:0] == 2'b11) begin
                // The lower half is already here, so skip straight to the next word
                // A buffered compressed half is fetched again, which costs no extra cycle
                mem_req_pc   = next_pc;
                next_pc_d    = next_pc + fetch_pkg::word_step;
                first_half_d = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            first_half <= 1'b0;
            buf_valid  <= 1'b0;
        end else begin
            first_half <= first_half_d;
            buf_valid  <= buf_valid_d;
        end
    end

    // Pc registers and the parked halfword
    always_ff @(posedge clk) begin
        latched_pc <= latched_pc_d;
        next_pc    <= next_pc_d;
        buf_half   <= buf_half_d;
    end

    assign mem.req_valid        = mem_req_valid;
    assign mem.req_pc           = mem_req_pc;
    assign mem.req_reason       = mem_req_reason;
    assign cache.resp_valid     = resp_valid;
    assign cache.resp_pc        = resp_pc;
    assign cache.resp_instr     = resp_instr;
    assign cache.resp_exception = resp_exception;

endmodule

`default_nettype wire

//--- icache/icache_word.sv
`timescale 1ns/1ps
`default_nettype none

// Word-aligned instruction store with one cycle of latency
// It ignores the low two pc bits and knows nothing about compressed instructions
module icache_word (
    icache_if.provider                        cache,
    input  logic                              fill_valid,
    input  logic [fetch_pkg::mem_addr_bits-1:0] fill_addr,
    input  logic [31:0]                       fill_data
);

    logic                       clk;
    logic                       rstn;
    logic                       req_valid;
    logic [fetch_pkg::xlen-1:0] req_pc;

    assign clk       = cache.clk;
    assign rstn      = cache.rstn;
    assign req_valid = cache.req_valid;
    assign req_pc    = cache.req_pc;

    // Instruction words, loaded only through the fill port
    logic [31:0] mem_array [fetch_pkg::mem_words];

    // Word index taken from the request pc
    logic [fetch_pkg::mem_addr_bits-1:0] rd_index;

    // Request falls at or beyond the end of the store
    logic out_of_range;

    assign rd_index     = req_pc[fetch_pkg::mem_addr_bits+1:2];
    assign out_of_range = req_pc >= fetch_pkg::mem_limit;

    // Response registers
    logic                       resp_valid_q;
    logic                       resp_exception_q;
    logic [fetch_pkg::xlen-1:0] resp_pc_q;
    logic [31:0]                resp_instr_q;

    // A fill lands at the rising edge
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            mem_array[fill_addr] <= fill_data;
        end
    end

    // Every request gets exactly one response pulse in the next cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid_q     <= 1'b0;
            resp_exception_q <= 1'b0;
        end else begin
            resp_valid_q <= req_valid;
            if (req_valid) begin
                resp_exception_q <= out_of_range;
            end
        end
    end

    // The pc is echoed as sent, so the caller can tell which word faulted
    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_pc_q <= req_pc;
            // An out-of-range index would alias into the array, so no read is made
            if (out_of_range) begin
                resp_instr_q <= '0;
            end else begin
                resp_instr_q <= mem_array[rd_index];
            end
        end
    end

    assign cache.resp_valid     = resp_valid_q;
    assign cache.resp_pc        = resp_pc_q;
    assign cache.resp_instr     = resp_instr_q;
    assign cache.resp_exception = resp_exception_q;

endmodule

`default_nettype wire

//--- common/icache_if.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch request and response bus
// Requests and responses are single-cycle valid pulses with no back-pressure
interface icache_if (
    input logic clk,
    input logic rstn
);

    // Request side, driven by whoever wants an instruction
    logic                       req_valid;
    logic [fetch_pkg::xlen-1:0] req_pc;
    fetch_pkg::if_reason_t      req_reason;

    // Response side, driven by whoever holds the instructions
    logic                       resp_valid;
    logic [fetch_pkg::xlen-1:0] resp_pc;
    logic [31:0]                resp_instr;
    // Set when the fetch touched an address outside the store
    logic                       resp_exception;

    // The side that receives requests and answers them
    modport provider (
        input  clk,
        input  rstn,
        input  req_valid,
        input  req_pc,
        input  req_reason,
        output resp_valid,
        output resp_pc,
        output resp_instr,
        output resp_exception
    );

    // The side that issues requests and takes the answers
    modport user (
        input  clk,
        input  rstn,
        output req_valid,
        output req_pc,
        output req_reason,
        input  resp_valid,
        input  resp_pc,
        input  resp_instr,
        input  resp_exception
    );

endinterface

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Width of the program counter and of every address on the fetch buses
    localparam int xlen = 64;

    // Depth of the word-aligned instruction store, counted in 32-bit words
    localparam int mem_words = 256;

    // Width of a word index into the instruction store
    localparam int mem_addr_bits = $clog2(mem_words);

    // Byte distance from one instruction word to the next
    localparam logic [xlen-1:0] word_step = 4;

    // First byte address past the end of the store
    // Any fetch at or above this address raises an access exception
    localparam logic [xlen-1:0] mem_limit = mem_words * 4;

    // Reason attached to every fetch request
    // A prefetch always continues straight on from the previous instruction
    // The adapter relies on that to reuse a buffered upper halfword
    // A predict goes to a target guessed by the branch predictor
    // A mispredict is a redirect after the pipeline found a wrong guess
    typedef enum logic [1:0] {
        if_prefetch,
        if_predict,
        if_mispredict
    } if_reason_t;

endpackage

`default_nettype wire
